// ==== tb.f ====
led_matrix_pkg.sv
led_matrix_if.sv
frame_write_port.sv
frame_ram.sv
scan_fsm.sv
plane_timer.sv
pixel_fetch.sv
led_matrix_top.sv
tb_panel_checker.sv
tb_led_matrix.sv

// ==== tb_led_matrix.sv ====
`default_nettype none

module tb_led_matrix;
    import led_matrix_pkg::*;

    localparam int PANEL_WIDTH      = 16;
    localparam int PANEL_HEIGHT     = 8;
    localparam int BASE_ON_CYCLES   = 4;
    localparam int AW               = $clog2(PANEL_WIDTH * PANEL_HEIGHT);
    localparam int DEPTH            = PANEL_WIDTH * PANEL_HEIGHT;
    localparam int NUM_WRITES       = 64;
    localparam int TOTAL_WRITES     = DEPTH + NUM_WRITES;  // Fill pass, then random writes
    localparam int HANDSHAKE_CYCLES = 6;
    localparam int PLANES_PER_FRAME = COLOR_DEPTH * PANEL_HEIGHT / 2;
    // Shifting per column is three cycles, plus latch overhead and the longest on-time
    localparam int PLANE_CYCLES     = 3*PANEL_WIDTH + 4 + (BASE_ON_CYCLES << (COLOR_DEPTH - 1));
    localparam int FRAME_CYCLES     = PLANES_PER_FRAME * PLANE_CYCLES;
    localparam int TIMEOUT_CYCLES   = TOTAL_WRITES*HANDSHAKE_CYCLES + 3*FRAME_CYCLES + 20;

    logic                               clk_root;
    logic                               rst_n;
    logic                               wr_req;
    logic [AW-1:0]                      wr_addr;
    pixel_t                             wr_data;
    logic                               wr_ack;
    rgb_t                               rgb_top;
    rgb_t                               rgb_bottom;
    logic                               clk_pixel;
    logic                               row_latch;
    logic [$clog2(PANEL_HEIGHT/2)-1:0]  row_addr;
    logic                               output_enable;
    logic                               write_done;

    pixel_t        frame_model [DEPTH];  // What the panel should show
    integer        seed;
    int            cycle_count = 0;
    int            tb_errors   = 0;
    int            total_errors;
    int            target;
    logic [AW-1:0] addr;
    pixel_t        data;

    led_matrix_top #(
        .PANEL_WIDTH    (PANEL_WIDTH),
        .PANEL_HEIGHT   (PANEL_HEIGHT),
        .BASE_ON_CYCLES (BASE_ON_CYCLES)
    ) u_led_matrix_top (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .wr_req        (wr_req),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_ack        (wr_ack),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .row_addr      (row_addr),
        .output_enable (output_enable)
    );

    tb_panel_checker #(
        .PANEL_WIDTH    (PANEL_WIDTH),
        .PANEL_HEIGHT   (PANEL_HEIGHT),
        .BASE_ON_CYCLES (BASE_ON_CYCLES)
    ) u_panel_checker (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .wr_req        (wr_req),
        .wr_ack        (wr_ack),
        .write_done    (write_done),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .row_addr      (row_addr),
        .output_enable (output_enable)
    );

    initial begin
        clk_root = 1'b0;
        forever #10 clk_root = ~clk_root;
    end

    // One four-phase handshake, called right after a rising edge
    task host_write(input logic [AW-1:0] waddr, input pixel_t wdata);
        wr_req  <= 1'b1;
        wr_addr <= waddr;
        wr_data <= wdata;
        @(posedge clk_root);
        while (!wr_ack) @(posedge clk_root);
        frame_model[waddr] <= wdata; // RAM takes the word on this edge too
        write_done <= 1'b1;
        wr_req     <= 1'b0;
        @(posedge clk_root);
        write_done <= 1'b0;
        while (wr_ack) @(posedge clk_root);
    endtask

    always @(posedge clk_root) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        seed       = 32'h64f5;
        rst_n      = 1'b0;
        wr_req     = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        write_done = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            frame_model[i] = 'x;
        end
        repeat (2) @(posedge clk_root);
        rst_n <= 1'b1;

        for (int i = 0; i < TOTAL_WRITES; i++) begin
            addr = (i < DEPTH) ? AW'(i) : AW'($random(seed));
            data = pixel_t'($random(seed));
            host_write(addr, data);
        end

        // Two more frames so the last writes are shown and compared
        target = u_panel_checker.latch_count + 2*PLANES_PER_FRAME;
        while (u_panel_checker.latch_count < target) @(negedge clk_root);
        @(negedge clk_root);

        if (u_panel_checker.planes_checked == 0) begin
            tb_errors++;
            $display("No bit plane was ever compared with the frame model");
        end
        total_errors = u_panel_checker.error_count + tb_errors;
        $display("Errors: %0d  (planes compared %0d, skipped %0d)", total_errors,
                 u_panel_checker.planes_checked, u_panel_checker.planes_skipped);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_panel_checker.sv ====
`default_nettype none

module tb_panel_checker #(
    parameter int PANEL_WIDTH    = 16,
    parameter int PANEL_HEIGHT   = 8,
    parameter int BASE_ON_CYCLES = 4
) (
    input wire                                clk_root,
    input wire                                rst_n,
    input wire                                wr_req,
    input wire                                wr_ack,
    input wire                                write_done,
    input wire led_matrix_pkg::rgb_t          rgb_top,
    input wire led_matrix_pkg::rgb_t          rgb_bottom,
    input wire                                clk_pixel,
    input wire                                row_latch,
    input wire [$clog2(PANEL_HEIGHT/2)-1:0]   row_addr,
    input wire                                output_enable
);
    import led_matrix_pkg::*;

    localparam int ROWS = PANEL_HEIGHT / 2;

    int   error_count    = 0;
    int   latch_count    = 0;
    int   planes_checked = 0;
    int   planes_skipped = 0;
    rgb_t top_seen [PANEL_WIDTH];
    rgb_t bot_seen [PANEL_WIDTH];
    int   pulses;
    int   plane;        // Plane being shifted in
    int   row_pair;
    int   shown_row;    // Row pair on the panel since the last latch
    int   on_len;
    int   on_expected;
    logic lit_seen;     // An on-time pulse ended since the last latch
    logic dirty;        // A host write landed while this plane was shifted
    logic first_cycle;
    logic clk_pixel_q;
    logic oe_q;
    logic ack_q;
    logic req_q;

    // Bit p of red, green and blue, red in bit 0
    function automatic rgb_t channel_bits(input pixel_t pix, input int p);
        rgb_t bits;
        bits[0] = pix[p];
        bits[1] = pix[COLOR_DEPTH + p];
        bits[2] = pix[2*COLOR_DEPTH + p];
        return bits;
    endfunction

    task automatic compare_row();
        pixel_t pix_top;
        pixel_t pix_bot;
        for (int c = 0; c < PANEL_WIDTH; c++) begin
            pix_top = tb_led_matrix.frame_model[row_pair*PANEL_WIDTH + c];
            pix_bot = tb_led_matrix.frame_model[(row_pair + ROWS)*PANEL_WIDTH + c];
            // Never-written pixels have no defined colour
            if (!$isunknown(pix_top) && top_seen[c] !== channel_bits(pix_top, plane)) begin
                error_count++;
                $display("[ERROR] rgb_top row pair %0d plane %0d col %0d: exp 0x%h, got 0x%h",
                         row_pair, plane, c, channel_bits(pix_top, plane), top_seen[c]);
            end
            if (!$isunknown(pix_bot) && bot_seen[c] !== channel_bits(pix_bot, plane)) begin
                error_count++;
                $display("[ERROR] rgb_bottom row pair %0d plane %0d col %0d: exp 0x%h, got 0x%h",
                         row_pair, plane, c, channel_bits(pix_bot, plane), bot_seen[c]);
            end
        end
    endtask

    always @(posedge clk_root) begin
        if (!rst_n) begin
            pulses      = 0;
            plane       = 0;
            row_pair    = 0;
            shown_row   = 0;
            on_len      = 0;
            on_expected = 0;
            lit_seen    = 1'b1; // Nothing was lit before the first latch
            dirty       = 1'b0;
            first_cycle = 1'b1;
            clk_pixel_q = 1'b0;
            oe_q        = 1'b0;
            ack_q       = 1'b0;
            req_q       = 1'b0;
        end else begin
            if (first_cycle && (clk_pixel || row_latch || output_enable || wr_ack)) begin
                error_count++;
                $display("Panel or host outputs were not idle right after reset");
            end
            first_cycle = 1'b0;

            // Four-phase handshake
            if (wr_ack && !ack_q && !req_q) begin
                error_count++;
                $display("wr_ack rose although wr_req was low");
            end
            if (!wr_ack && ack_q && req_q) begin
                error_count++;
                $display("wr_ack fell while wr_req was still high");
            end

            if (write_done) dirty = 1'b1;

            if (clk_pixel && !clk_pixel_q) begin
                if (pulses < PANEL_WIDTH) begin
                    top_seen[pulses] = rgb_top;
                    bot_seen[pulses] = rgb_bottom;
                end
                pulses++;
            end

            if (output_enable) begin
                on_len++;
            end else if (oe_q) begin
                if (on_len != on_expected) begin
                    error_count++;
                    $display("[ERROR] output_enable on-time: exp 0x%h, got 0x%h",
                             on_expected, on_len);
                end
                on_len   = 0;
                lit_seen = 1'b1;
            end

            if (row_latch) begin
                if (output_enable) begin
                    error_count++;
                    $display("output_enable was high during row_latch");
                end
                if (!lit_seen) begin
                    error_count++;
                    $display("The previous plane was never lit by output_enable");
                end
                if (pulses != PANEL_WIDTH) begin
                    error_count++;
                    $display("Saw %0d pixel clocks between latches instead of %0d",
                             pulses, PANEL_WIDTH);
                end
                if (row_addr !== row_pair) begin
                    error_count++;
                    $display("[ERROR] row_addr at latch: exp 0x%h, got 0x%h", row_pair, row_addr);
                end
                if (dirty) begin
                    planes_skipped++;
                end else begin
                    compare_row();
                    planes_checked++;
                end
                shown_row   = row_pair;
                on_expected = BASE_ON_CYCLES << plane;
                latch_count++;
                pulses   = 0;
                dirty    = 1'b0;
                lit_seen = 1'b0;
                // Planes first, then row pairs
                if (plane == COLOR_DEPTH - 1) begin
                    plane    = 0;
                    row_pair = (row_pair == ROWS - 1) ? 0 : row_pair + 1;
                end else begin
                    plane++;
                end
            end else if (row_addr !== shown_row) begin
                error_count++;
                $display("[ERROR] row_addr between latches: exp 0x%h, got 0x%h",
                         shown_row, row_addr);
            end

            clk_pixel_q = clk_pixel;
            oe_q        = output_enable;
            ack_q       = wr_ack;
            req_q       = wr_req;
        end
    end

endmodule

`default_nettype wire

// ==== led_matrix_top.sv ====
`default_nettype none

module led_matrix_top #(
    parameter int PANEL_WIDTH    = 16,
    parameter int PANEL_HEIGHT   = 8,
    parameter int BASE_ON_CYCLES = 4
) (
    input  wire                                         clk_root,
    input  wire                                         rst_n,
    input  wire                                         wr_req,
    input  wire [$clog2(PANEL_WIDTH*PANEL_HEIGHT)-1:0]  wr_addr,
    input  wire led_matrix_pkg::pixel_t                 wr_data,
    output logic                                        wr_ack,
    output led_matrix_pkg::rgb_t                        rgb_top,
    output led_matrix_pkg::rgb_t                        rgb_bottom,
    output logic                                        clk_pixel,
    output logic                                        row_latch,
    output logic [$clog2(PANEL_HEIGHT/2)-1:0]           row_addr,
    output logic                                        output_enable
);
    import led_matrix_pkg::*;

    localparam int AW = $clog2(PANEL_WIDTH * PANEL_HEIGHT);

    logic          ram_we;
    logic [AW-1:0] ram_waddr;
    pixel_t        ram_wdata;
    logic [AW-1:0] raddr_top;
    logic [AW-1:0] raddr_bottom;
    pixel_t        rdata_top;
    pixel_t        rdata_bottom;
    logic          timer_start;
    plane_t        timer_plane;
    logic          timer_done;

    pixel_fetch_if #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) fetch_bus ();

    frame_write_port #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) u_write_port (
        .clk_root  (clk_root),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_ack    (wr_ack),
        .ram_we    (ram_we),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata)
    );

    frame_ram #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) u_frame_ram (
        .clk_root     (clk_root),
        .we           (ram_we),
        .waddr        (ram_waddr),
        .wdata        (ram_wdata),
        .raddr_top    (raddr_top),
        .raddr_bottom (raddr_bottom),
        .rdata_top    (rdata_top),
        .rdata_bottom (rdata_bottom)
    );

    scan_fsm #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) u_scan_fsm (
        .clk_root    (clk_root),
        .rst_n       (rst_n),
        .fetch       (fetch_bus.sequencer),
        .timer_start (timer_start),
        .timer_plane (timer_plane),
        .timer_done  (timer_done),
        .clk_pixel   (clk_pixel),
        .row_latch   (row_latch),
        .row_addr    (row_addr),
        .rgb_top     (rgb_top),
        .rgb_bottom  (rgb_bottom)
    );

    plane_timer #(.BASE_ON_CYCLES(BASE_ON_CYCLES)) u_plane_timer (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .start         (timer_start),
        .plane         (timer_plane),
        .output_enable (output_enable),
        .done          (timer_done)
    );

    pixel_fetch #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) u_pixel_fetch (
        .clk_root     (clk_root),
        .rst_n        (rst_n),
        .fetch        (fetch_bus.fetcher),
        .raddr_top    (raddr_top),
        .raddr_bottom (raddr_bottom),
        .rdata_top    (rdata_top),
        .rdata_bottom (rdata_bottom)
    );

endmodule

`default_nettype wire

// ==== pixel_fetch.sv ====
`default_nettype none

module pixel_fetch #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire                                          clk_root,
    input  wire                                          rst_n,
    pixel_fetch_if.fetcher                               fetch,
    output logic [$clog2(PANEL_WIDTH*PANEL_HEIGHT)-1:0]  raddr_top,
    output logic [$clog2(PANEL_WIDTH*PANEL_HEIGHT)-1:0]  raddr_bottom,
    input  wire led_matrix_pkg::pixel_t                  rdata_top,
    input  wire led_matrix_pkg::pixel_t                  rdata_bottom
);
    import led_matrix_pkg::*;

    localparam int AW   = $clog2(PANEL_WIDTH * PANEL_HEIGHT);
    localparam int HALF = PANEL_WIDTH * PANEL_HEIGHT / 2; // Offset of the bottom half

    logic   valid_d;
    plane_t plane_d;

    // Pick one bit of each channel for the given plane
    function automatic rgb_t plane_bits(input pixel_t pix, input plane_t p);
        rgb_t bits;
        bits[RGB_RED]   = pix[RED_LSB + p];
        bits[RGB_GREEN] = pix[GREEN_LSB + p];
        bits[RGB_BLUE]  = pix[BLUE_LSB + p];
        return bits;
    endfunction

    assign raddr_top    = AW'(fetch.row_pair * PANEL_WIDTH + fetch.column);
    assign raddr_bottom = AW'(raddr_top + HALF);

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            valid_d          <= 1'b0;
            fetch.bits_valid <= 1'b0;
        end else begin
            valid_d          <= fetch.fetch_req; // Stage 1, RAM read
            fetch.bits_valid <= valid_d;         // Stage 2, bit select
        end
    end

    // Plane rides alongside the RAM read
    always_ff @(posedge clk_root) begin
        plane_d <= fetch.plane;
        if (valid_d) begin
            fetch.rgb_top    <= plane_bits(rdata_top, plane_d);
            fetch.rgb_bottom <= plane_bits(rdata_bottom, plane_d);
        end
    end

endmodule

`default_nettype wire

// ==== plane_timer.sv ====
`default_nettype none

module plane_timer #(
    parameter int BASE_ON_CYCLES = 4
) (
    input  wire                          clk_root,
    input  wire                          rst_n,
    input  wire                          start,
    input  wire led_matrix_pkg::plane_t  plane,
    output logic                         output_enable,
    output logic                         done
);
    import led_matrix_pkg::*;

    on_time_t count;
    on_time_t count_next;

    always_comb begin
        count_next = count;
        if (start) begin
            count_next = on_time_t'(BASE_ON_CYCLES) << plane; // Weight doubles per plane
        end else if (count != '0) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            count         <= '0;
            output_enable <= 1'b0;
        end else begin
            count         <= count_next;
            // Panel pin straight from a flop, mirrors count != 0
            output_enable <= (count_next != '0);
        end
    end

    // Idle whenever nothing is lit, so high out of reset
    assign done = ~output_enable;

endmodule

`default_nettype wire

// ==== scan_fsm.sv ====
`default_nettype none

module scan_fsm #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire                                   clk_root,
    input  wire                                   rst_n,
    pixel_fetch_if.sequencer                      fetch,
    output logic                                  timer_start,
    output led_matrix_pkg::plane_t                timer_plane,
    input  wire                                   timer_done,
    output logic                                  clk_pixel,
    output logic                                  row_latch,
    output logic [$clog2(PANEL_HEIGHT/2)-1:0]     row_addr,
    output led_matrix_pkg::rgb_t                  rgb_top,
    output led_matrix_pkg::rgb_t                  rgb_bottom
);
    import led_matrix_pkg::*;

    localparam int COL_W = $clog2(PANEL_WIDTH);
    localparam int ROW_W = $clog2(PANEL_HEIGHT / 2);

    typedef enum logic [2:0] {FETCH, WAIT_BITS, SHIFT, WAIT_ON, LATCH, START_ON} state_t;

    state_t           state;
    logic [COL_W-1:0] column;   // Column of the next fetch
    logic [ROW_W-1:0] row_pair;
    plane_t           plane;

    // Column has wrapped to 0 in SHIFT once the last pixel is out
    assign fetch.fetch_req = (state == FETCH) || (state == SHIFT && column != '0);
    assign fetch.column    = column;
    assign fetch.row_pair  = row_pair;
    assign fetch.plane     = plane;

    assign timer_start = (state == START_ON);
    assign timer_plane = plane; // Still the plane just latched

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state      <= FETCH;
            column     <= '0;
            row_pair   <= '0;
            plane      <= '0;
            clk_pixel  <= 1'b0;
            row_latch  <= 1'b0;
            row_addr   <= '0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            clk_pixel <= 1'b0;
            row_latch <= 1'b0;
            case (state)
                FETCH: state <= WAIT_BITS;
                WAIT_BITS: if (fetch.bits_valid) begin
                    rgb_top    <= fetch.rgb_top;
                    rgb_bottom <= fetch.rgb_bottom;
                    clk_pixel  <= 1'b1; // Rises with the new data, held one cycle
                    column     <= (column == COL_W'(PANEL_WIDTH - 1)) ? '0 : column + 1'b1;
                    state      <= SHIFT;
                end
                SHIFT: state <= (column == '0) ? WAIT_ON : WAIT_BITS;
                WAIT_ON: if (timer_done) begin // Previous plane is dark
                    row_latch <= 1'b1;
                    row_addr  <= row_pair;
                    state     <= LATCH;
                end
                LATCH: state <= START_ON;
                START_ON: begin
                    if (plane == plane_t'(COLOR_DEPTH - 1)) begin
                        plane    <= '0;
                        row_pair <= (row_pair == ROW_W'(PANEL_HEIGHT/2 - 1)) ? '0
                                                                             : row_pair + 1'b1;
                    end else begin
                        plane <= plane + 1'b1;
                    end
                    state <= FETCH;
                end
                default: state <= FETCH;
            endcase
        end
    end

    // Latching over a lit plane would show half-shifted data
    a_latch_when_dark: assert property (@(posedge clk_root) disable iff (!rst_n)
        row_latch |-> timer_done)
        else $error("row_latch high while a plane is still lit");

endmodule

`default_nettype wire

// ==== frame_ram.sv ====
`default_nettype none

module frame_ram #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire                                          clk_root,
    input  wire                                          we,
    input  wire [$clog2(PANEL_WIDTH*PANEL_HEIGHT)-1:0]   waddr,
    input  wire led_matrix_pkg::pixel_t                  wdata,
    input  wire [$clog2(PANEL_WIDTH*PANEL_HEIGHT)-1:0]   raddr_top,
    input  wire [$clog2(PANEL_WIDTH*PANEL_HEIGHT)-1:0]   raddr_bottom,
    output led_matrix_pkg::pixel_t                       rdata_top,
    output led_matrix_pkg::pixel_t                       rdata_bottom
);
    import led_matrix_pkg::*;

    localparam int DEPTH = PANEL_WIDTH * PANEL_HEIGHT;

    // Row-major, index is row * PANEL_WIDTH + column
    pixel_t mem [DEPTH];

    // Host write port
    always_ff @(posedge clk_root) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Two registered read ports for the two panel halves
    // A read that collides with a write sees the old word
    always_ff @(posedge clk_root) begin
        rdata_top    <= mem[raddr_top];
        rdata_bottom <= mem[raddr_bottom];
    end

endmodule

`default_nettype wire

// ==== frame_write_port.sv ====
`default_nettype none

module frame_write_port #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire                                          clk_root,
    input  wire                                          rst_n,
    input  wire                                          wr_req,
    input  wire [$clog2(PANEL_WIDTH*PANEL_HEIGHT)-1:0]   wr_addr,
    input  wire led_matrix_pkg::pixel_t                  wr_data,
    output logic                                         wr_ack,
    output logic                                         ram_we,
    output logic [$clog2(PANEL_WIDTH*PANEL_HEIGHT)-1:0]  ram_waddr,
    output led_matrix_pkg::pixel_t                       ram_wdata
);
    typedef enum logic {IDLE, ACKED} state_t;

    state_t state;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state  <= IDLE;
            ram_we <= 1'b0;
        end else begin
            ram_we <= 1'b0; // Single-cycle strobe
            case (state)
                IDLE: if (wr_req) begin
                    ram_we <= 1'b1;
                    state  <= ACKED;
                end
                ACKED: if (!wr_req) state <= IDLE; // Host finished phase 3
                default: state <= IDLE;
            endcase
        end
    end

    // Capture the word on the same edge that arms the write
    always_ff @(posedge clk_root) begin
        if (state == IDLE && wr_req) begin
            ram_waddr <= wr_addr;
            ram_wdata <= wr_data;
        end
    end

    assign wr_ack = (state == ACKED);

    a_ack_needs_req: assert property (@(posedge clk_root) disable iff (!rst_n)
        $rose(wr_ack) |-> $past(wr_req))
        else $error("wr_ack rose without a pending wr_req");

    a_single_write: assert property (@(posedge clk_root) disable iff (!rst_n)
        ram_we |=> !ram_we)
        else $error("ram_we high in two consecutive cycles");

endmodule

`default_nettype wire

// ==== led_matrix_if.sv ====
`default_nettype none

interface pixel_fetch_if #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
);
    import led_matrix_pkg::*;

    // Request side, one item in flight at a time
    logic                                fetch_req;
    logic [$clog2(PANEL_WIDTH)-1:0]      column;
    logic [$clog2(PANEL_HEIGHT/2)-1:0]   row_pair;
    plane_t                              plane;

    // Answer two cycles after the request
    logic                                bits_valid;
    rgb_t                                rgb_top;
    rgb_t                                rgb_bottom;

    modport sequencer (
        output fetch_req, column, row_pair, plane,
        input  bits_valid, rgb_top, rgb_bottom
    );

    modport fetcher (
        input  fetch_req, column, row_pair, plane,
        output bits_valid, rgb_top, rgb_bottom
    );

endinterface

`default_nettype wire

// ==== led_matrix_pkg.sv ====
`default_nettype none

package led_matrix_pkg;

    // Bits per colour channel
    localparam int COLOR_DEPTH = 4;

    // Field positions inside a packed pixel
    localparam int RED_LSB   = 0;
    localparam int GREEN_LSB = COLOR_DEPTH;
    localparam int BLUE_LSB  = 2 * COLOR_DEPTH;

    // Bit positions inside one panel colour triplet
    localparam int RGB_RED   = 0;
    localparam int RGB_GREEN = 1;
    localparam int RGB_BLUE  = 2;

    // Blue, green, red from high to low
    typedef logic [3*COLOR_DEPTH-1:0] pixel_t;

    // Current bit plane, 0 is the least significant
    typedef logic [$clog2(COLOR_DEPTH)-1:0] plane_t;

    // One RGB triplet as it goes to the panel
    typedef logic [2:0] rgb_t;

    // Wide enough for the base on-time shifted by the top plane
    typedef logic [15:0] on_time_t;

endpackage

`default_nettype wire
